/* ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // field widths
    //////////////////////////////////////////////////////////////////////

    localparam int OPCODE_W = 6;
    localparam int ALU_FN_W = 4;
    localparam int MEM_OP_W = 3;
    localparam int WB_OP_W = 2;

    // immediate flag in bit 0, alu function right above it
    localparam int IMM_BIT = 0;
    localparam int ALU_FN_LSB = 1;

    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [ALU_FN_W-1:0] alu_fn_t;

    //////////////////////////////////////////////////////////////////////
    // opcode classes
    //////////////////////////////////////////////////////////////////////

    // alu ops below JUMP_FIRST, illegal from ILLEGAL_FIRST up
    localparam opcode_t JUMP_FIRST = opcode_t'(32);
    localparam opcode_t ILLEGAL_FIRST = opcode_t'(40);

    //////////////////////////////////////////////////////////////////////
    // stage operation selectors
    //////////////////////////////////////////////////////////////////////

    // codes 5 to 7 behave as MEM_NONE
    typedef enum logic [MEM_OP_W-1:0] {
        MEM_NONE  = 3'd0,
        MEM_LOAD  = 3'd1,
        MEM_STORE = 3'd2,
        MEM_IN    = 3'd3,
        MEM_OUT   = 3'd4
    } mem_op_t;

    // code 3 behaves as WB_NONE
    typedef enum logic [WB_OP_W-1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2
    } wb_op_t;

endpackage

`default_nettype wire

/* fetch_fsm.sv */
`default_nettype none

module fetch_fsm #(
    parameter int IRQ_ENTRY_CYCLES = 2
) (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire ctrl_pkg::opcode_t   opcode,
    input  wire                      pc_w,
    input  wire                      i_pending,
    input  wire                      i_odv,
    input  wire                      mem_idle,
    output logic                     i_req,
    output logic                     ir_load,
    output logic                     imm_load,
    output ctrl_pkg::alu_fn_t        alu_fn,
    output logic                     int_ack,
    output logic                     pc_load,
    output logic                     illegal,
    output logic                     issue
);

    localparam int CNT_W = $clog2(IRQ_ENTRY_CYCLES + 1);

    typedef enum logic [3:0] {
        F_IDLE,
        F_PC_WRITE,
        F_IRQ,
        F_FETCH,
        F_DECODE,
        F_IMM_FETCH,
        F_IMM_LOAD,
        F_DISPATCH,
        F_JUMP,
        F_ILLEGAL
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t state_next;
    logic [CNT_W-1:0] irq_cnt;
    ctrl_pkg::opcode_t ir_q;

    //////////////////////////////////////////////////////////////////////
    // state and interrupt entry counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge g_clk)
    begin
        if (rst)
        begin
            state <= F_IDLE;
            irq_cnt <= '0;
        end
        else
        begin
            state <= state_next;
            // load on entry, count down to zero while inside
            if (state_next == F_IRQ && state != F_IRQ)
                irq_cnt <= CNT_W'(IRQ_ENTRY_CYCLES - 1);
            else if (irq_cnt != '0)
                irq_cnt <= irq_cnt - 1'b1;
        end
    end

    // instruction register
    always_ff @(posedge g_clk)
    begin
        if (state == F_FETCH && i_odv)
            ir_q <= opcode;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            F_IDLE:
            begin
                // hold off until the memory stage is free
                if (mem_idle)
                begin
                    if (pc_w)
                        state_next = F_PC_WRITE;
                    else if (i_pending)
                        state_next = F_IRQ;
                    else
                        state_next = F_FETCH;
                end
            end
            F_PC_WRITE:
                state_next = i_pending ? F_IRQ : F_FETCH;
            F_IRQ:
                if (irq_cnt == '0)
                    state_next = F_FETCH;
            F_FETCH:
                if (i_odv)
                    state_next = F_DECODE;
            F_DECODE:
            begin
                if (ir_q >= ctrl_pkg::ILLEGAL_FIRST)
                    state_next = F_ILLEGAL;
                else if (ir_q >= ctrl_pkg::JUMP_FIRST)
                    state_next = F_JUMP;
                else if (ir_q[ctrl_pkg::IMM_BIT])
                    state_next = F_IMM_FETCH;
                else
                    state_next = F_DISPATCH;
            end
            F_IMM_FETCH:
                if (i_odv)
                    state_next = F_IMM_LOAD;
            F_IMM_LOAD:
                state_next = F_DISPATCH;
            F_DISPATCH:
                if (mem_idle)
                    state_next = F_IDLE;
            default:
                state_next = F_IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////////////////////////

    assign i_req = (state == F_FETCH) || (state == F_IMM_FETCH);
    assign ir_load = (state == F_DECODE);
    assign imm_load = (state == F_IMM_LOAD);
    assign int_ack = (state == F_IRQ);
    assign pc_load = (state == F_PC_WRITE) || (state == F_JUMP);
    assign illegal = (state == F_ILLEGAL);
    assign issue = (state == F_DISPATCH) && mem_idle;

    assign alu_fn = ir_q[ctrl_pkg::ALU_FN_LSB +: ctrl_pkg::ALU_FN_W];

endmodule

`default_nettype wire

/* mem_fsm.sv */
`default_nettype none

module mem_fsm (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire                      issue,
    input  wire ctrl_pkg::mem_op_t   mem_op,
    input  wire                      mem_rdy,
    input  wire                      d_odv,
    input  wire                      hs_in,
    input  wire                      wb_idle,
    output logic                     mem_idle,
    output logic                     d_req,
    output logic                     d_we,
    output logic                     hs_out,
    output logic                     wb_issue
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_XFER,
        M_LOAD_WAIT,
        M_HS_REQ,
        M_HS_REL,
        M_DONE
    } mem_state_t;

    mem_state_t state;
    mem_state_t state_next;
    ctrl_pkg::mem_op_t op_q;

    always_ff @(posedge g_clk)
    begin
        if (rst)
            state <= M_IDLE;
        else
            state <= state_next;
    end

    // operation held for the whole transfer
    always_ff @(posedge g_clk)
    begin
        if (state == M_IDLE && issue)
            op_q <= mem_op;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            M_IDLE:
            begin
                if (issue)
                begin
                    case (mem_op)
                        ctrl_pkg::MEM_LOAD,
                        ctrl_pkg::MEM_STORE: state_next = M_XFER;
                        ctrl_pkg::MEM_IN,
                        ctrl_pkg::MEM_OUT:   state_next = M_HS_REQ;
                        default:             state_next = M_DONE;
                    endcase
                end
            end
            M_XFER:
                if (mem_rdy)
                    state_next = (op_q == ctrl_pkg::MEM_LOAD) ? M_LOAD_WAIT : M_DONE;
            M_LOAD_WAIT:
                if (d_odv)
                    state_next = M_DONE;
            M_HS_REQ:
                if (hs_in)
                    state_next = M_HS_REL;
            // port must drop its side before we finish
            M_HS_REL:
                if (!hs_in)
                    state_next = M_DONE;
            M_DONE:
                if (wb_idle)
                    state_next = M_IDLE;
            default:
                state_next = M_IDLE;
        endcase
    end

    assign mem_idle = (state == M_IDLE);
    assign d_req = (state == M_XFER);
    assign d_we = (state == M_XFER) && (op_q == ctrl_pkg::MEM_STORE);
    assign hs_out = (state == M_HS_REQ);
    assign wb_issue = (state == M_DONE) && wb_idle;

endmodule

`default_nettype wire

/* wb_fsm.sv */
`default_nettype none

module wb_fsm (
    input  wire                     g_clk,
    input  wire                     rst,
    input  wire                     wb_issue,
    input  wire ctrl_pkg::wb_op_t   wb_op,
    output logic                    wb_idle,
    output logic                    reg_we,
    output logic                    wb_sel
);

    typedef enum logic {
        W_IDLE,
        W_BUSY
    } wb_state_t;

    wb_state_t state;
    logic we_q;
    logic sel_q;

    always_ff @(posedge g_clk)
    begin
        if (rst)
            state <= W_IDLE;
        else if (state == W_IDLE && wb_issue)
            state <= W_BUSY;
        else
            state <= W_IDLE;
    end

    // write enable and source for the held item
    always_ff @(posedge g_clk)
    begin
        if (state == W_IDLE && wb_issue)
        begin
            we_q <= (wb_op == ctrl_pkg::WB_ALU) || (wb_op == ctrl_pkg::WB_MEM);
            sel_q <= (wb_op == ctrl_pkg::WB_MEM);
        end
    end

    assign wb_idle = (state == W_IDLE);
    assign reg_we = (state == W_BUSY) && we_q;
    assign wb_sel = (state == W_BUSY) && sel_q;

endmodule

`default_nettype wire

/* pipe_controller.sv */
`default_nettype none

module pipe_controller #(
    parameter int IRQ_ENTRY_CYCLES = 2
) (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire ctrl_pkg::opcode_t   opcode,
    input  wire                      pc_w,
    input  wire                      i_pending,
    input  wire                      i_odv,
    input  wire ctrl_pkg::mem_op_t   mem_op,
    input  wire                      mem_rdy,
    input  wire                      d_odv,
    input  wire                      hs_in,
    input  wire ctrl_pkg::wb_op_t    wb_op,
    output logic                     i_req,
    output logic                     ir_load,
    output logic                     imm_load,
    output ctrl_pkg::alu_fn_t        alu_fn,
    output logic                     int_ack,
    output logic                     pc_load,
    output logic                     illegal,
    output logic                     d_req,
    output logic                     d_we,
    output logic                     hs_out,
    output logic                     reg_we,
    output logic                     wb_sel
);

    // stage handoff
    logic issue;
    logic mem_idle;
    logic wb_issue;
    logic wb_idle;

    fetch_fsm #(
        .IRQ_ENTRY_CYCLES(IRQ_ENTRY_CYCLES)
    ) u_fetch (
        .g_clk    (g_clk),
        .rst      (rst),
        .opcode   (opcode),
        .pc_w     (pc_w),
        .i_pending(i_pending),
        .i_odv    (i_odv),
        .mem_idle (mem_idle),
        .i_req    (i_req),
        .ir_load  (ir_load),
        .imm_load (imm_load),
        .alu_fn   (alu_fn),
        .int_ack  (int_ack),
        .pc_load  (pc_load),
        .illegal  (illegal),
        .issue    (issue)
    );

    mem_fsm u_mem (
        .g_clk   (g_clk),
        .rst     (rst),
        .issue   (issue),
        .mem_op  (mem_op),
        .mem_rdy (mem_rdy),
        .d_odv   (d_odv),
        .hs_in   (hs_in),
        .wb_idle (wb_idle),
        .mem_idle(mem_idle),
        .d_req   (d_req),
        .d_we    (d_we),
        .hs_out  (hs_out),
        .wb_issue(wb_issue)
    );

    wb_fsm u_wb (
        .g_clk   (g_clk),
        .rst     (rst),
        .wb_issue(wb_issue),
        .wb_op   (wb_op),
        .wb_idle (wb_idle),
        .reg_we  (reg_we),
        .wb_sel  (wb_sel)
    );

endmodule

`default_nettype wire

/* pipe_controller_sva.sv */
`default_nettype none

module pipe_controller_sva (
    input wire g_clk,
    input wire rst,
    input wire i_req,
    input wire i_odv,
    input wire ir_load,
    input wire imm_load,
    input wire int_ack,
    input wire pc_load,
    input wire illegal,
    input wire d_req,
    input wire d_we,
    input wire mem_rdy,
    input wire hs_out,
    input wire hs_in,
    input wire reg_we,
    input wire wb_sel,
    input wire issue,
    input wire mem_idle,
    input wire wb_issue,
    input wire wb_idle
);

    int unsigned fail_cnt = 0;

    //////////////////////////////////////////////////////////////////////
    // reset state and fetch strobes
    //////////////////////////////////////////////////////////////////////

    a_reset: assert property (@(posedge g_clk) rst |=> !(i_req || ir_load || imm_load
        || int_ack || pc_load || illegal || d_req || hs_out || reg_we || issue
        || wb_issue) && mem_idle && wb_idle)
        else begin $error("strobe active or stage busy after reset"); fail_cnt++; end

    // two cycles of interrupt entry
    a_ack_len: assert property (@(posedge g_clk) disable iff (rst)
        $rose(int_ack) |-> int_ack ##1 int_ack ##1 !int_ack)
        else begin $error("int_ack length wrong"); fail_cnt++; end

    a_i_req_hold: assert property (@(posedge g_clk) disable iff (rst)
        i_req && !i_odv |=> i_req)
        else begin $error("i_req dropped before i_odv"); fail_cnt++; end

    a_one_shot: assert property (@(posedge g_clk) disable iff (rst)
        (ir_load |=> !ir_load) and (imm_load |=> !imm_load)
        and (pc_load |=> !pc_load) and (illegal |=> !illegal))
        else begin $error("fetch strobe longer than one cycle"); fail_cnt++; end

    //////////////////////////////////////////////////////////////////////
    // memory, port and write-back rules
    //////////////////////////////////////////////////////////////////////

    a_d_req_hold: assert property (@(posedge g_clk) disable iff (rst)
        d_req && !mem_rdy |=> d_req && $stable(d_we))
        else begin $error("d_req or d_we changed before mem_rdy"); fail_cnt++; end

    a_hs_hold: assert property (@(posedge g_clk) disable iff (rst)
        (hs_out && !hs_in |=> hs_out) and (hs_out && hs_in |=> !hs_out))
        else begin $error("hs_out broke the port handshake"); fail_cnt++; end

    // no new memory strobe until the port has dropped hs_in
    a_hs_release: assert property (@(posedge g_clk) disable iff (rst)
        ($rose(hs_out) || $rose(d_req)) |-> !hs_in)
        else begin $error("memory strobe raised while hs_in still high"); fail_cnt++; end

    a_handoff: assert property (@(posedge g_clk) disable iff (rst)
        (issue |=> !mem_idle) and (wb_issue |=> !wb_idle))
        else begin $error("receiving stage still idle after issue"); fail_cnt++; end

    a_reg_we: assert property (@(posedge g_clk) disable iff (rst)
        (reg_we |=> !reg_we) and (wb_sel |-> reg_we))
        else begin $error("reg_we longer than one cycle or wb_sel alone"); fail_cnt++; end

endmodule

bind pipe_controller pipe_controller_sva u_sva (
    .g_clk(g_clk), .rst(rst), .i_req(i_req), .i_odv(i_odv), .ir_load(ir_load),
    .imm_load(imm_load), .int_ack(int_ack), .pc_load(pc_load), .illegal(illegal),
    .d_req(d_req), .d_we(d_we), .mem_rdy(mem_rdy), .hs_out(hs_out), .hs_in(hs_in),
    .reg_we(reg_we), .wb_sel(wb_sel), .issue(issue), .mem_idle(mem_idle),
    .wb_issue(wb_issue), .wb_idle(wb_idle)
);

`default_nettype wire

/* tb_pipe_controller.sv */
`default_nettype none

module tb_pipe_controller;

    localparam int NUM_INSTR = 12;

    logic g_clk = 1'b0;
    logic rst;
    ctrl_pkg::opcode_t opcode;
    logic pc_w, i_pending, i_odv;
    ctrl_pkg::mem_op_t mem_op;
    logic mem_rdy, d_odv, hs_in;
    ctrl_pkg::wb_op_t wb_op;
    wire i_req, ir_load, imm_load, int_ack, pc_load, illegal;
    wire d_req, d_we, hs_out, reg_we, wb_sel;
    ctrl_pkg::alu_fn_t alu_fn;

    integer seed = 89608;
    int err_cnt = 0;
    int cnt_ir = 0, cnt_imm = 0, cnt_pc = 0, cnt_ill = 0, cnt_ack = 0, cnt_dreq = 0, cnt_hs = 0;
    int exp_ir = 0, exp_imm = 0, exp_pc = 0, exp_ill = 0, exp_dreq = 0, exp_hs = 0;
    logic prev_dreq = 1'b0, prev_hs = 1'b0;
    logic instr_valid = 1'b0;
    logic exp_we = 1'b0;
    logic sel_head;
    ctrl_pkg::opcode_t cur_opcode = '0;
    ctrl_pkg::wb_op_t cur_wb_op = ctrl_pkg::WB_NONE;
    ctrl_pkg::wb_op_t wb_pipe[$];
    logic exp_sel[$];

    pipe_controller #(.IRQ_ENTRY_CYCLES(2)) UUT (
        .g_clk(g_clk), .rst(rst), .opcode(opcode), .pc_w(pc_w), .i_pending(i_pending),
        .i_odv(i_odv), .mem_op(mem_op), .mem_rdy(mem_rdy), .d_odv(d_odv), .hs_in(hs_in),
        .wb_op(wb_op), .i_req(i_req), .ir_load(ir_load), .imm_load(imm_load),
        .alu_fn(alu_fn), .int_ack(int_ack), .pc_load(pc_load), .illegal(illegal),
        .d_req(d_req), .d_we(d_we), .hs_out(hs_out), .reg_we(reg_we), .wb_sel(wb_sel)
    );

    always #5 g_clk = ~g_clk;

    function automatic int rand_delay();
        rand_delay = $unsigned($random(seed)) % 4;
    endfunction

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // responders for instruction, data memory and port sides
    //////////////////////////////////////////////////////////////////////

    always
    begin
        @(negedge g_clk);
        if (!rst && i_req && instr_valid)
        begin
            repeat (rand_delay()) @(negedge g_clk);
            i_odv = 1'b1;
            @(negedge g_clk);
            i_odv = 1'b0;
        end
    end

    always
    begin : data_side
        logic is_load;
        @(negedge g_clk);
        if (!rst && d_req)
        begin
            is_load = !exp_we;
            repeat (rand_delay()) @(negedge g_clk);
            mem_rdy = 1'b1;
            @(negedge g_clk);
            mem_rdy = 1'b0;
            if (is_load)
            begin
                repeat (rand_delay()) @(negedge g_clk);
                d_odv = 1'b1;
                @(negedge g_clk);
                d_odv = 1'b0;
            end
        end
    end

    always
    begin
        @(negedge g_clk);
        if (!rst && hs_out)
        begin
            repeat (rand_delay()) @(negedge g_clk);
            hs_in = 1'b1;
            @(negedge g_clk);
            repeat (rand_delay()) @(negedge g_clk);
            hs_in = 1'b0;
        end
    end

    // datapath write-back registers follow the issue order
    always @(negedge g_clk)
        wb_op = (wb_pipe.size() != 0) ? wb_pipe[0] : ctrl_pkg::WB_NONE;

    always @(posedge g_clk)
    begin
        if (!rst)
        begin
            if (ir_load && alu_fn !== cur_opcode[4:1])
            begin
                $display("MISMATCH alu_fn: got %h expected %h", alu_fn, cur_opcode[4:1]);
                err_cnt++;
            end
            if (d_req && d_we !== exp_we)
            begin
                $display("MISMATCH d_we: got %h expected %h", d_we, exp_we);
                err_cnt++;
            end
            if (reg_we && exp_sel.size() == 0)
            begin
                $display("reg_we pulsed with no register write outstanding");
                err_cnt++;
            end
            else if (reg_we)
            begin
                sel_head = exp_sel.pop_front();
                if (wb_sel !== sel_head)
                begin
                    $display("MISMATCH wb_sel: got %h expected %h", wb_sel, sel_head);
                    err_cnt++;
                end
            end
            cnt_ir += ir_load;
            cnt_imm += imm_load;
            cnt_pc += pc_load;
            cnt_ill += illegal;
            cnt_ack += int_ack;
            cnt_dreq += (d_req && !prev_dreq);
            cnt_hs += (hs_out && !prev_hs);
            prev_dreq = d_req;
            prev_hs = hs_out;
            if (UUT.wb_issue && wb_pipe.size() != 0)
                void'(wb_pipe.pop_front());
            if (UUT.issue)
            begin
                wb_pipe.push_back(cur_wb_op);
                exp_we = (mem_op == ctrl_pkg::MEM_STORE);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction stream
    //////////////////////////////////////////////////////////////////////

    task automatic run_instr(input ctrl_pkg::opcode_t op, input ctrl_pkg::mem_op_t mop,
                             input ctrl_pkg::wb_op_t wop);
        @(negedge g_clk);
        cur_opcode = op;
        opcode = op;
        mem_op = mop;
        cur_wb_op = wop;
        instr_valid = 1'b1;
        exp_ir++;
        if (op < 6'd32)
        begin
            exp_imm += op[0];
            exp_dreq += (mop == ctrl_pkg::MEM_LOAD || mop == ctrl_pkg::MEM_STORE);
            exp_hs += (mop == ctrl_pkg::MEM_IN || mop == ctrl_pkg::MEM_OUT);
            if (wop == ctrl_pkg::WB_ALU || wop == ctrl_pkg::WB_MEM)
                exp_sel.push_back(wop == ctrl_pkg::WB_MEM);
        end
        else if (op < 6'd40)
            exp_pc++;
        else
            exp_ill++;
        do
            @(posedge g_clk);
        while (!(UUT.issue || pc_load || illegal));
    endtask

    initial
    begin
        rst = 1'b1;
        opcode = '0;
        pc_w = 1'b1;
        i_pending = 1'b1;
        i_odv = 1'b0;
        mem_op = ctrl_pkg::MEM_NONE;
        mem_rdy = 1'b0;
        d_odv = 1'b0;
        hs_in = 1'b0;
        wb_op = ctrl_pkg::WB_NONE;
        repeat (5) @(negedge g_clk);
        rst = 1'b0;
        @(negedge g_clk);
        pc_w = 1'b0;
        @(negedge g_clk);
        i_pending = 1'b0;
        exp_pc = 1;
        run_instr(6'd4, ctrl_pkg::MEM_NONE, ctrl_pkg::WB_ALU);
        run_instr(6'd7, ctrl_pkg::MEM_LOAD, ctrl_pkg::WB_MEM);
        run_instr(6'd10, ctrl_pkg::MEM_STORE, ctrl_pkg::WB_NONE);
        run_instr(6'd13, ctrl_pkg::MEM_IN, ctrl_pkg::WB_MEM);
        run_instr(6'd35, ctrl_pkg::MEM_LOAD, ctrl_pkg::WB_ALU);
        run_instr(6'd2, ctrl_pkg::MEM_OUT, ctrl_pkg::WB_NONE);
        run_instr(6'd45, ctrl_pkg::MEM_STORE, ctrl_pkg::WB_ALU);
        run_instr(6'd31, ctrl_pkg::MEM_LOAD, ctrl_pkg::WB_ALU);
        run_instr(6'd16, ctrl_pkg::MEM_IN, ctrl_pkg::WB_ALU);
        run_instr(6'd63, ctrl_pkg::MEM_OUT, ctrl_pkg::WB_MEM);
        run_instr(6'd9, ctrl_pkg::MEM_STORE, ctrl_pkg::WB_MEM);
        run_instr(6'd22, ctrl_pkg::MEM_NONE, ctrl_pkg::WB_MEM);
        @(negedge g_clk);
        instr_valid = 1'b0;
        // drain the memory and write-back stages
        while (exp_sel.size() != 0 || !UUT.mem_idle || !UUT.wb_idle)
            @(posedge g_clk);
        repeat (4) @(posedge g_clk);
        check_count("ir_load", cnt_ir, exp_ir);
        check_count("imm_load", cnt_imm, exp_imm);
        check_count("pc_load", cnt_pc, exp_pc);
        check_count("illegal", cnt_ill, exp_ill);
        check_count("int_ack", cnt_ack, 2);
        check_count("d_req", cnt_dreq, exp_dreq);
        check_count("hs_out", cnt_hs, exp_hs);
        $display("errors: %0d checks, %0d assertions", err_cnt, UUT.u_sva.fail_cnt);
        if (err_cnt == 0 && UUT.u_sva.fail_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (200 * NUM_INSTR + 20) @(posedge g_clk);
        $display("timeout: pipeline did not finish the instruction stream");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
ctrl_pkg.sv
fetch_fsm.sv
mem_fsm.sv
wb_fsm.sv
pipe_controller.sv
pipe_controller_sva.sv
tb_pipe_controller.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log
rm -f sim.log && \
verilator --binary --timing --assert --top-module tb_pipe_controller -f sim.f -o tb_sim && \
./obj_dir/tb_sim +verilator+error+limit+100 | tee sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
